// File: hdl/fetch_pkg.sv
// ----------------------------------------
// Widths, opcodes and bundle types for the RV32IC fetch unit
// Imported with a wildcard by every fetch RTL module
// ----------------------------------------
package fetch_pkg;

  localparam int xlen = 32;

  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;  // Boot address

  // Major opcodes
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  localparam logic [1:0] burst_incr = 2'b01;  // AXI INCR

  // Full 32-bit encoding, J-type immediate layout
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [4:0] imm19_15;  // Upper part of imm19_12
    logic [2:0] funct3;    // Also imm14_12 for J-type
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_full_t;

  // Compressed encoding in the low halfword
  typedef struct packed {
    logic [15:0] upper;     // Next parcel, unused for a 16-bit instruction
    logic [2:0]  funct3;
    logic [10:0] offset;    // Bits 12:2, CJ offset scrambled
    logic [1:0]  quadrant;
  } instr_comp_t;

  typedef union packed {
    instr_full_t full;
    instr_comp_t comp;
  } instr_word_t;

  // Read address channel, halfword address
  typedef struct packed {
    logic [xlen-1:1] addr;
    logic            valid;
    logic [1:0]      burst;
  } ar_req_t;

  // Read data channel
  typedef struct packed {
    logic [xlen-1:0] data;
    logic [1:0]      resp;
    logic            last;
    logic            valid;
  } r_resp_t;

  typedef struct packed {
    logic            compressed;
    logic            is_jump;
    logic            is_branch;
    logic [xlen-1:0] target;  // Direct jump target
  } predecode_t;

  // Fetch to decode
  typedef struct packed {
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
    logic            compressed;
    logic            is_branch;
    logic            jump_taken;
  } fetch_bundle_t;

  // Misprediction or exception from later stages
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] target;
  } redirect_t;

endpackage

// File: hdl/fetch_bus_master.sv
// ----------------------------------------
// Single-beat read master on the AXI read channels
// Runs one instruction fetch per fetch_req, pulses fetch_done at the end
// ----------------------------------------
`timescale 1ns/1ps

module fetch_bus_master
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  // Request from PC control
  input  logic            fetch_req,
  input  logic [xlen-1:0] fetch_addr,
  output logic            fetch_done,
  output instr_word_t     fetch_word,

  // Read address channel
  output ar_req_t         ar,
  input  logic            ar_ready,

  // Read data channel
  input  r_resp_t         r,
  output logic            r_ready
);

  typedef enum logic [1:0] {
    st_idle = 2'b00,
    st_addr = 2'b01,
    st_data = 2'b10
  } bus_state_t;

  bus_state_t      state;
  logic            done_q;
  logic [xlen-1:1] addr_q;  // Halfword address
  instr_word_t     word_q;

  logic start;
  logic addr_hs;
  logic data_hs;

  // fetch_req is still high in the done cycle, so it must not restart
  assign start   = (state == st_idle) && fetch_req && !done_q;
  assign addr_hs = ar.valid && ar_ready;
  assign data_hs = r.valid && r_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= st_idle;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        st_idle: begin
          if (start) state <= st_addr;
        end
        st_addr: begin
          if (addr_hs) state <= st_data;
        end
        st_data: begin
          if (data_hs) begin
            state  <= st_idle;
            done_q <= 1'b1;  // One-cycle pulse
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) addr_q <= fetch_addr[xlen-1:1];
    if (data_hs) word_q <= r.data;  // Response code ignored
  end

  always_comb begin
    ar.addr  = addr_q;
    ar.valid = (state == st_addr);
    ar.burst = burst_incr;  // Single beat
  end

  assign r_ready    = (state == st_data);
  assign fetch_done = done_q;
  assign fetch_word = word_q;

endmodule

// File: hdl/fetch_predecode.sv
// ----------------------------------------
// Predecode of one fetched word: compressed, direct jumps, branches
// Purely combinational, also forms the direct jump target
// ----------------------------------------
`timescale 1ns/1ps

module fetch_predecode
  import fetch_pkg::*;
(
  input  logic [xlen-1:0] pc,
  input  instr_word_t     word,
  output predecode_t      info
);

  instr_full_t full;
  instr_comp_t comp;

  logic            compressed;
  logic            quad1;
  logic            c_jump;
  logic            c_branch;
  logic            full_jump;
  logic            full_branch;
  logic [xlen-1:0] j_imm;
  logic [xlen-1:0] cj_imm;
  logic [xlen-1:0] offset;

  assign full = word.full;
  assign comp = word.comp;

  // Anything but 2'b11 in the low bits is a 16-bit parcel
  assign compressed = (comp.quadrant != 2'b11);
  assign quad1      = (comp.quadrant == 2'b01);

  // C.J is 101, C.JAL is 001 (RV32 only)
  assign c_jump   = quad1 && ((comp.funct3 == 3'b101) || (comp.funct3 == 3'b001));
  // C.BEQZ 110, C.BNEZ 111
  assign c_branch = quad1 && ((comp.funct3 == 3'b110) || (comp.funct3 == 3'b111));

  assign full_jump   = (full.opcode == opc_jal);
  assign full_branch = (full.opcode == opc_branch);

  // J-type imm[20|10:1|11|19:12]
  assign j_imm = {
    {11{full.imm20}},
    full.imm20,
    full.imm19_15,
    full.funct3,
    full.imm11,
    full.imm10_1,
    1'b0
  };

  // CJ offset bits 12:2 hold imm[11|4|9:8|10|6|7|3:1|5]
  assign cj_imm = {
    {20{comp.offset[10]}},
    comp.offset[10],      // imm11
    comp.offset[6],       // imm10
    comp.offset[8:7],     // imm9:8
    comp.offset[4],       // imm7
    comp.offset[5],       // imm6
    comp.offset[0],       // imm5
    comp.offset[9],       // imm4
    comp.offset[3:1],     // imm3:1
    1'b0
  };

  assign offset = compressed ? cj_imm : j_imm;

  always_comb begin
    info.compressed = compressed;
    if (compressed) begin
      info.is_jump   = c_jump;
      info.is_branch = c_branch;
    end else begin
      info.is_jump   = full_jump;
      info.is_branch = full_branch;
    end
    info.target = pc + offset;  // Only meaningful when is_jump
  end

endmodule

// File: hdl/fetch_pc_ctrl.sv
// ----------------------------------------
// PC owner: redirect and jump priority, stale read tracking
// Delivers each good word to decode over a four-phase req/ack exchange
// ----------------------------------------
`timescale 1ns/1ps

module fetch_pc_ctrl
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  redirect_t       redirect,

  // Bus master side
  output logic            fetch_req,
  output logic [xlen-1:0] fetch_addr,
  input  logic            fetch_done,
  input  instr_word_t     fetch_word,
  input  predecode_t      info,

  // Decode side
  output fetch_bundle_t   out_bundle,
  output logic            req,
  input  logic            ack
);

  typedef enum logic [1:0] {
    st_fetch   = 2'b00,  // Bus read outstanding
    st_deliver = 2'b01,  // req high, waiting for ack
    st_release = 2'b10   // req low, waiting for ack low
  } pc_state_t;

  pc_state_t       state;
  logic [xlen-1:0] pc_q;
  logic            fetch_req_q;
  logic            req_q;
  logic            stale_q;
  redirect_t       pend_q;
  redirect_t       pend_next;
  fetch_bundle_t   bundle_q;

  logic            word_good;
  logic [xlen-1:0] seq_pc;
  logic [xlen-1:0] next_pc;

  // Newest redirect wins over an older pending one
  assign pend_next = redirect.valid ? redirect : pend_q;

  assign seq_pc    = pc_q + (info.compressed ? 32'd2 : 32'd4);
  assign next_pc   = info.is_jump ? info.target : seq_pc;

  // A redirect in the return cycle also kills the word
  assign word_good = fetch_done && !stale_q && !redirect.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= st_release;  // First fetch once ack is low
      pc_q        <= reset_pc;
      fetch_req_q <= 1'b0;
      req_q       <= 1'b0;
      stale_q     <= 1'b0;
      pend_q      <= '0;
    end else begin
      pend_q <= pend_next;
      case (state)
        st_fetch: begin
          if (redirect.valid) stale_q <= 1'b1;
          if (fetch_done) begin
            fetch_req_q <= 1'b0;
            if (word_good) begin
              pc_q  <= next_pc;
              req_q <= 1'b1;
              state <= st_deliver;
            end else begin
              state <= st_release;  // Stale word dropped
            end
          end
        end
        st_deliver: begin
          if (ack) begin
            req_q <= 1'b0;
            state <= st_release;
          end
        end
        st_release: begin
          if (!ack) begin
            fetch_req_q <= 1'b1;
            stale_q     <= 1'b0;
            pend_q      <= '0;
            if (pend_next.valid) pc_q <= pend_next.target;
            state <= st_fetch;
          end
        end
        default: state <= st_release;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (word_good) begin
      bundle_q.instr      <= fetch_word;
      bundle_q.pc         <= pc_q;
      bundle_q.compressed <= info.compressed;
      bundle_q.is_branch  <= info.is_branch;  // Predicted not taken
      bundle_q.jump_taken <= info.is_jump;
    end
  end

  assign fetch_req  = fetch_req_q;
  assign fetch_addr = pc_q;
  assign req        = req_q;
  assign out_bundle = bundle_q;

endmodule

// File: hdl/fetch_top.sv
// ----------------------------------------
// Fetch subsystem top: bus master, predecode and PC control
// ----------------------------------------
`timescale 1ns/1ps

module fetch_top
  import fetch_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  redirect_t     redirect,

  // Read address channel
  output ar_req_t       ar,
  input  logic          ar_ready,

  // Read data channel
  input  r_resp_t       r,
  output logic          r_ready,

  // Decode exchange
  output fetch_bundle_t out_bundle,
  output logic          req,
  input  logic          ack
);

  logic            fetch_req;
  logic [xlen-1:0] fetch_addr;
  logic            fetch_done;
  instr_word_t     fetch_word;
  predecode_t      info;

  fetch_bus_master u_bus (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_done (fetch_done),
    .fetch_word (fetch_word),
    .ar         (ar),
    .ar_ready   (ar_ready),
    .r          (r),
    .r_ready    (r_ready)
  );

  // PC of the word in flight, stable until fetch_done
  fetch_predecode u_predecode (
    .pc   (fetch_addr),
    .word (fetch_word),
    .info (info)
  );

  fetch_pc_ctrl u_pc_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect   (redirect),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .fetch_done (fetch_done),
    .fetch_word (fetch_word),
    .info       (info),
    .out_bundle (out_bundle),
    .req        (req),
    .ack        (ack)
  );

endmodule

// File: tb/fetch_mem_model.sv
// ----------------------------------------
// Halfword-addressable instruction memory on the AXI read channels
// Random ready and valid delays, stall holds back the data beat
// ----------------------------------------
`timescale 1ns/1ps

module fetch_mem_model
  import fetch_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  ar_req_t ar,
  output logic    ar_ready,
  output r_resp_t r,
  input  logic    r_ready,
  input  logic    stall     // Keeps r.valid low while high
);

  logic [15:0]     mem [0:1023];  // Loaded by the testbench
  logic            busy;
  logic [xlen-1:1] addr_q;
  logic [9:0]      idx;
  int              a_wait;
  int              r_wait;

  assign idx = addr_q[10:1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_ready <= 1'b0;
      r        <= '0;
      busy     <= 1'b0;
      addr_q   <= '0;
      a_wait   <= 0;
      r_wait   <= 0;
    end else begin
      ar_ready <= 1'b0;
      if (!busy) begin
        if (ar.valid && ar_ready) begin
          busy   <= 1'b1;
          addr_q <= ar.addr;
          a_wait <= $urandom_range(3, 0);
          r_wait <= $urandom_range(3, 0);
        end else if (ar.valid) begin
          if (a_wait == 0) ar_ready <= 1'b1;
          else a_wait <= a_wait - 1;
        end
      end else begin
        if (r.valid && r_ready) begin
          r.valid <= 1'b0;
          busy    <= 1'b0;
        end else if (!r.valid && !stall) begin
          if (r_wait == 0) begin
            r.valid <= 1'b1;
            r.data  <= {mem[idx + 10'd1], mem[idx]};  // One beat, any halfword
            r.resp  <= 2'b00;
            r.last  <= 1'b1;
          end else begin
            r_wait <= r_wait - 1;
          end
        end
      end
    end
  end

endmodule

// File: tb/fetch_tb.sv
// ----------------------------------------
// Directed testbench for the fetch subsystem
// Decode side driver, reference PC walk and per-test summary
// ----------------------------------------
`timescale 1ns/1ps

module fetch_tb
  import fetch_pkg::*;
;

  logic          clk;
  logic          rst_n;
  redirect_t     redirect;
  ar_req_t       ar;
  logic          ar_ready;
  r_resp_t       r;
  logic          r_ready;
  fetch_bundle_t out_bundle;
  logic          req;
  logic          ack;
  logic          stall;

  int          errors;
  int          checks;
  int          tests;
  logic [31:0] exp_pc;
  ar_req_t     ar_seen;  // Last read address accepted by the bus

  fetch_top dut0 (
    .clk(clk), .rst_n(rst_n), .redirect(redirect),
    .ar(ar), .ar_ready(ar_ready), .r(r), .r_ready(r_ready),
    .out_bundle(out_bundle), .req(req), .ack(ack)
  );

  fetch_mem_model mem0 (
    .clk(clk), .rst_n(rst_n), .ar(ar), .ar_ready(ar_ready),
    .r(r), .r_ready(r_ready), .stall(stall)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    if (ar.valid && ar_ready) ar_seen <= ar;
  end

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic check_bundle(input fetch_bundle_t got, input fetch_bundle_t exp,
                              input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h exp %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_pc(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got pc %h exp pc %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_ar(input ar_req_t got, input ar_req_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h exp %h", $time, msg, got, exp);
    end
  endtask

  task automatic put16(input logic [31:0] a, input logic [15:0] h);
    mem0.mem[a[10:1]] = h;
  endtask

  task automatic put32(input logic [31:0] a, input logic [31:0] w);
    put16(a, w[15:0]);
    put16(a + 2, w[31:16]);
  endtask

  function automatic logic [31:0] enc_jal(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
  endfunction

  function automatic logic [15:0] enc_cj(input logic [2:0] f3, input logic [11:0] off);
    return {f3, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1], off[5], 2'b01};
  endfunction

  // Reference walk step, straight from the ISA encodings
  function automatic fetch_bundle_t expect_at(input logic [31:0] pc, output logic [31:0] nxt);
    fetch_bundle_t b;
    logic [31:0]   w;
    logic          jump;
    logic [31:0]   off;
    w = {mem0.mem[pc[10:1] + 10'd1], mem0.mem[pc[10:1]]};
    b.instr = w;
    b.pc = pc;
    b.compressed = (w[1:0] != 2'b11);
    if (b.compressed) begin
      jump = (w[1:0] == 2'b01) && (w[15:13] == 3'b101 || w[15:13] == 3'b001);
      b.is_branch = (w[1:0] == 2'b01) && (w[15:13] == 3'b110 || w[15:13] == 3'b111);
      off = {{21{w[12]}}, w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
    end else begin
      jump = (w[6:0] == 7'b1101111);
      b.is_branch = (w[6:0] == 7'b1100011);
      off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    end
    b.jump_taken = jump;
    nxt = jump ? pc + off : pc + (b.compressed ? 32'd2 : 32'd4);
    return b;
  endfunction

  task automatic wait_req(input logic level, output logic ok);
    int n;
    n = 0;
    while (req !== level && n < 200) begin
      tick();
      n++;
    end
    ok = (req === level);
    if (!ok) begin
      errors++;
      $display("Timed out waiting for req to go %0b at %0t", level, $time);
    end
  endtask

  // One four-phase exchange checked against the reference walk
  task automatic deliver_one();
    fetch_bundle_t exp;
    ar_req_t       exp_ar;
    logic [31:0]   nxt;
    logic          ok;
    wait_req(1'b1, ok);
    if (ok) begin
      exp = expect_at(exp_pc, nxt);
      exp_ar.addr  = exp_pc[31:1];
      exp_ar.valid = 1'b1;
      exp_ar.burst = 2'b01;  // INCR
      check_ar(ar_seen, exp_ar, "read address");
      check_pc(out_bundle.pc, exp_pc, "delivered pc");
      check_bundle(out_bundle, exp, "bundle");
      exp_pc = nxt;
      ack = 1'b1;
      wait_req(1'b0, ok);
      ack = 1'b0;
      tick();
    end
  endtask

  task automatic pulse_redirect(input logic [31:0] target);
    redirect.valid = 1'b1;
    redirect.target = target;
    tick();
    redirect = '0;
  endtask

  task automatic start_test(input logic [31:0] fill_pc);
    rst_n = 1'b0;
    ack = 1'b0;
    redirect = '0;
    stall = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      mem0.mem[i] = {i[9:0], 6'b000000};  // Quadrant 0, never a jump
    end
    repeat (16) tick();
    exp_pc = fill_pc;
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    if (errors == err0) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - err0);
  endtask

  task automatic test_sequential();
    int err0;
    err0 = errors;
    start_test(reset_pc);
    for (int i = 0; i < 5; i++) put32(4 * i, 32'h00100093 + (i << 20));
    rst_n = 1'b1;
    for (int i = 0; i < 5; i++) deliver_one();
    end_test("sequential", err0);
  endtask

  task automatic test_mixed();
    int err0;
    err0 = errors;
    start_test(reset_pc);
    put16(0, 16'h0505);
    put32(2, 32'h00208113);  // 32-bit at halfword address
    put16(6, 16'h0001);
    put32(8, 32'h00310193);
    put16(12, 16'h852a);
    put32(14, 32'h00418213);
    rst_n = 1'b1;
    for (int i = 0; i < 6; i++) deliver_one();
    end_test("mixed", err0);
  endtask

  task automatic test_jumps();
    int err0;
    err0 = errors;
    start_test(reset_pc);
    put32(0, enc_jal(21'd16));
    put16(16, enc_cj(3'b101, -12'sd8));   // Back to 8
    put16(8, enc_cj(3'b001, 12'd20));     // Forward to 28
    put32(28, enc_jal(-21'sd28));         // Back to 0
    rst_n = 1'b1;
    for (int i = 0; i < 6; i++) deliver_one();
    end_test("jumps", err0);
  endtask

  task automatic test_branches();
    int err0;
    err0 = errors;
    start_test(reset_pc);
    put32(0, 32'h04000063);  // beq +64
    put16(4, 16'hc001);      // c.beqz
    put16(6, 16'he001);      // c.bnez
    put32(8, 32'h00001463);  // bne +8
    put32(12, 32'h00100093);
    rst_n = 1'b1;
    for (int i = 0; i < 5; i++) deliver_one();
    end_test("branches", err0);
  endtask

  task automatic test_redirect();
    int err0;
    int n;
    err0 = errors;
    start_test(reset_pc);
    put32(0, 32'h00100093);
    put32(4, enc_jal(21'd32));  // Loses to the redirect
    put32(32'h40, 32'h00200113);
    put32(32'h44, 32'h00300193);
    put32(32'h80, 32'h00400213);
    rst_n = 1'b1;
    deliver_one();
    stall = 1'b1;
    n = 0;
    while (!(ar.valid || r_ready) && n < 200) begin
      tick();
      n++;
    end
    if (n >= 200) begin
      errors++;
      $display("Timed out waiting for the bus read at %0t", $time);
    end
    repeat (3) tick();
    pulse_redirect(32'h40);
    stall = 1'b0;
    exp_pc = 32'h40;
    deliver_one();
    deliver_one();
    n = 0;
    while (req !== 1'b1 && n < 200) begin
      tick();
      n++;
    end
    if (req !== 1'b1) begin
      errors++;
      $display("Timed out waiting for req before the second redirect at %0t", $time);
    end
    pulse_redirect(32'h80);  // Current bundle still completes
    deliver_one();
    exp_pc = 32'h80;
    deliver_one();
    end_test("redirect", err0);
  endtask

  task automatic test_ack_hold();
    int            err0;
    logic          ok;
    logic [31:0]   nxt;
    fetch_bundle_t held;
    err0 = errors;
    start_test(reset_pc);
    for (int i = 0; i < 4; i++) put32(4 * i, 32'h00500293 + (i << 20));
    rst_n = 1'b1;
    deliver_one();
    wait_req(1'b1, ok);
    held = expect_at(exp_pc, nxt);
    for (int i = 0; i < 60; i++) begin
      tick();
      check_bundle(out_bundle, held, "bundle while ack held off");
      if (req !== 1'b1 || ar.valid !== 1'b0) begin
        errors++;
        $display("[FAIL] %0t req dropped or bus read started during stall", $time);
      end
    end
    deliver_one();
    deliver_one();
    end_test("ack hold", err0);
  endtask

  initial begin
    void'($urandom(32'h0897cfdd));
    clk = 1'b0;
    rst_n = 1'b0;
    redirect = '0;
    ack = 1'b0;
    stall = 1'b0;
    errors = 0;
    checks = 0;
    tests = 0;
    test_sequential();
    test_mixed();
    test_jumps();
    test_branches();
    test_redirect();
    test_ack_hold();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
hdl/fetch_pkg.sv
hdl/fetch_bus_master.sv
hdl/fetch_predecode.sv
hdl/fetch_pc_ctrl.sv
hdl/fetch_top.sv
tb/fetch_mem_model.sv
tb/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/fetch_bus_master.sv
      - hdl/fetch_predecode.sv
      - hdl/fetch_pc_ctrl.sv
      - hdl/fetch_top.sv
  - target: test
    files:
      - tb/fetch_mem_model.sv
      - tb/fetch_tb.sv
